//--- compile.f
+incdir+bench
src/mips_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
bench/mips_core_properties.sv
bench/tb_mips_core.sv

//--- bench/mips_ref_model.svh
// ============================================================
// Test program table, memory fill pattern and
// in-order ISA reference model for the core testbench
// ============================================================

`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

localparam int PROG_LEN = 24;

word_t prog [PROG_LEN];

// ========================================================
// Encoders
// ========================================================
function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs, input int rt);
    return {OPC_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

// Depends on all six index bits
function automatic word_t fill_word(input int unsigned idx);
    return 32'hc0de_0000 ^ (idx * 32'h0001_0203) ^ (idx << 26);
endfunction

task automatic load_program();
    prog[0]  = enc_i(OPC_ADDI, 1, 0, 5);
    prog[1]  = enc_i(OPC_ADDI, 2, 0, -3);       // Negative immediate
    prog[2]  = enc_r(FUNCT_ADD, 3, 1, 2);       // Forward from MEM and WB
    prog[3]  = enc_r(FUNCT_SUB, 4, 3, 1);
    prog[4]  = enc_r(FUNCT_AND, 5, 4, 1);
    prog[5]  = enc_r(FUNCT_OR, 6, 5, 2);
    prog[6]  = enc_r(FUNCT_SLT, 7, 2, 1);
    prog[7]  = enc_i(OPC_ADDI, 8, 7, -1);
    prog[8]  = enc_i(OPC_ADDI, 0, 1, 7);        // Write to r0 that never retires
    prog[9]  = enc_i(OPC_SW, 3, 0, 8);
    prog[10] = enc_i(OPC_LW, 9, 0, 8);
    prog[11] = enc_r(FUNCT_ADD, 10, 9, 1);      // Load-use
    prog[12] = enc_i(OPC_SW, 10, 0, 16);
    prog[13] = enc_i(OPC_LW, 11, 0, 20);        // Reads the fill pattern
    prog[14] = enc_r(FUNCT_SUB, 12, 11, 9);     // Load-use again
    prog[15] = enc_i(OPC_BEQ, 1, 1, 2);         // Taken
    prog[16] = enc_i(OPC_ADDI, 13, 0, 99);      // Squashed
    prog[17] = enc_i(OPC_ADDI, 14, 0, 98);      // Squashed
    prog[18] = enc_i(OPC_BNE, 1, 1, 1);         // Not taken
    prog[19] = enc_i(OPC_ADDI, 15, 0, 77);
    prog[20] = enc_i(OPC_BNE, 1, 15, 1);        // Taken
    prog[21] = enc_i(OPC_ADDI, 16, 0, 1);       // Squashed
    prog[22] = enc_i(OPC_SW, 15, 0, 24);
    prog[23] = enc_i(OPC_BEQ, 0, 0, -1);        // Loop to itself
endtask

// ========================================================
// Reference model that fills the expected write and store lists
// ========================================================
task automatic run_ref_model();
    word_t regs [32];
    word_t dmem [64];
    word_t pc;
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    word_t res;
    int    idx;
    int    dst;
    logic  wr;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) dmem[i] = fill_word(i);
    pc = RESET_PC;
    for (int step = 0; step < 1000; step++) begin
        idx = int'((pc - RESET_PC) >> 2);
        ins = (idx >= 0 && idx < PROG_LEN) ? prog[idx] : '0;
        a   = regs[ins[25:21]];
        b   = regs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        wr  = 1'b0;
        dst = ins[20:16];
        pc  = pc + 4;
        case (ins[31:26])
            OPC_RTYPE: begin
                dst = ins[15:11];
                wr  = 1'b1;
                case (ins[5:0])
                    FUNCT_ADD: res = a + b;
                    FUNCT_SUB: res = a - b;
                    FUNCT_AND: res = a & b;
                    FUNCT_OR:  res = a | b;
                    FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:   wr = 1'b0;  // No-op
                endcase
            end
            OPC_ADDI: begin
                res = a + imm;
                wr  = 1'b1;
            end
            OPC_LW: begin
                res = dmem[(a + imm) >> 2 & 63];
                wr  = 1'b1;
            end
            OPC_SW: begin
                dmem[(a + imm) >> 2 & 63] = b;
                exp_st_addr.push_back(a + imm);
                exp_st_data.push_back(b);
            end
            OPC_BEQ, OPC_BNE: begin
                if ((a == b) == (ins[31:26] == OPC_BEQ)) begin
                    if (imm == 32'hffff_ffff) break;  // Final self-loop
                    pc = pc + (imm << 2);
                end
            end
            default: ;
        endcase
        if (wr && dst != 0) begin
            regs[dst] = res;
            exp_wr_addr.push_back(dst[4:0]);
            exp_wr_data.push_back(res);
        end
    end
endtask

`endif

//--- bench/tb_mips_core.sv
// ============================================================
// Testbench for mips_core with clock, reset, instruction ROM,
// Wishbone slave with random waits and retirement checks
// ============================================================

module tb_mips_core import mips_pkg::*; ();

    localparam word_t RESET_PC = 32'h0000_0100;

    logic      clk = 1'b0;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    word_t     wb_adr;
    word_t     wb_dat_w;
    word_t     wb_dat_r;
    logic      wb_ack;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    reg_addr_t exp_wr_addr [$];  // Expected register writes
    word_t     exp_wr_data [$];
    word_t     exp_st_addr [$];  // Expected stores
    word_t     exp_st_data [$];

    word_t slave_mem [64];
    word_t rng;                  // xorshift state
    logic  busy;                 // Request seen, waiting to ack
    int    wait_left;
    int    cycles;
    int    post_rst;             // Negedges since reset release

    `include "mips_ref_model.svh"

    localparam int TIMEOUT = 40 + PROG_LEN * 10;

    mips_core #(.RESET_PC(RESET_PC)) DUT (.*);

    always #50 clk = ~clk;  // Period 100

    // ========================================================
    // Helpers
    // ========================================================
    function automatic word_t xorshift32(input word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string test, input word_t exp, input word_t act);
        $display("** Error [%s] expected %h actual %h", test, exp, act);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // ========================================================
    // Instruction ROM driven on the falling edge
    // ========================================================
    always @(negedge clk) begin
        int idx;
        idx = int'((imem_addr - RESET_PC) >> 2);
        imem_data <= (idx >= 0 && idx < PROG_LEN) ? prog[idx] : '0;  // Outside table is a no-op
    end

    // ========================================================
    // Wishbone slave with 0 to 3 wait cycles
    // ========================================================
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;                     // One-cycle ack
        end else if (rst_n && wb_cyc && wb_stb) begin
            if (!busy) begin
                rng = xorshift32(rng);
                wait_left = int'(rng % 4);
                busy = 1'b1;
            end
            if (wait_left == 0) begin
                busy = 1'b0;
                wb_ack   <= 1'b1;
                wb_dat_r <= slave_mem[wb_adr[7:2]];
                if (wb_we) begin
                    slave_mem[wb_adr[7:2]] = wb_dat_w;
                    assert (exp_st_addr.size() > 0)
                    else report_failure("store issued beyond the expected list");
                    assert (wb_adr == exp_st_addr[0])
                    else report_mismatch("store address", exp_st_addr[0], wb_adr);
                    assert (wb_dat_w == exp_st_data[0])
                    else report_mismatch("store data", exp_st_data[0], wb_dat_w);
                    void'(exp_st_addr.pop_front());
                    void'(exp_st_data.pop_front());
                end
            end else begin
                wait_left--;
            end
        end
    end

    // ========================================================
    // Reset and retirement checks on the falling edge
    // ========================================================
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (imem_addr == RESET_PC) else report_mismatch("reset pc", RESET_PC, imem_addr);
            assert (!wb_cyc && !rf_we) else report_failure("outputs active during reset");
        end else begin
            post_rst++;
            if (post_rst <= 3)  // First instruction not yet in WB
                assert (!wb_cyc && !rf_we) else report_failure("outputs active before first retire");
            if (rf_we) begin
                assert (exp_wr_addr.size() > 0)
                else report_failure("register write beyond the expected list");
                assert (rf_waddr == exp_wr_addr[0])
                else report_mismatch("retire register", word_t'(exp_wr_addr[0]),
                                     word_t'(rf_waddr));
                assert (rf_wdata == exp_wr_data[0])
                else report_mismatch("retire data", exp_wr_data[0], rf_wdata);
                void'(exp_wr_addr.pop_front());
                void'(exp_wr_data.pop_front());
            end
        end
    end

    // Bound protocol and reset assertions
    always @(negedge clk) begin
        if (DUT.u_properties.fail_count != 0)
            report_failure("a bound protocol or reset assertion failed");
    end

    // Timeout counter runs from reset release
    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles >= TIMEOUT)
                report_failure(
                    "timeout, the core stopped retiring before the lists were consumed");
        end
    end

    // ========================================================
    // Main sequence
    // ========================================================
    initial begin
        rst_n     = 1'b0;
        imem_data = '0;
        wb_dat_r  = '0;
        wb_ack    = 1'b0;
        rng       = 32'h3e1e;
        busy      = 1'b0;
        wait_left = 0;
        cycles    = 0;
        post_rst  = 0;
        for (int i = 0; i < 64; i++) slave_mem[i] = fill_word(i);
        load_program();
        run_ref_model();
        repeat (5) @(negedge clk);
        rst_n <= 1'b1;
        while (exp_wr_addr.size() != 0 || exp_st_addr.size() != 0)
            @(posedge clk);
        repeat (20) @(negedge clk);  // Catch any late extra write
        if (DUT.u_properties.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure("a bound protocol or reset assertion failed");
        end
    end

endmodule

//--- bench/mips_core_properties.sv
// ============================================================
// Wishbone protocol, retirement and reset assertions,
// bound into mips_core
// ============================================================

module mips_core_properties import mips_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      wb_cyc,
    input logic      wb_stb,
    input logic      wb_we,
    input word_t     wb_adr,
    input word_t     wb_dat_w,
    input logic      wb_ack,
    input logic      rf_we,
    input reg_addr_t rf_waddr
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // Strobe only inside a cycle
    assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else begin
        $error("stb high without cyc");
        fail_count++;
    end

    // Request held stable until ack
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=>
        (wb_stb && $stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_we)))
    else begin
        $error("request changed before ack");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) rf_we |-> (rf_waddr != '0))
    else begin
        $error("retirement write to register 0");
        fail_count++;
    end

    // Quiet while in reset
    assert property (@(posedge clk) !rst_n |-> (!wb_cyc && !wb_stb && !rf_we))
    else begin
        $error("outputs active in reset");
        fail_count++;
    end

endmodule

bind mips_core mips_core_properties u_properties (.*);

//--- src/mips_core.sv
// ============================================================
// Five-stage in-order MIPS core, top level
// Stage wiring, writeback select and retirement port
// ============================================================

module mips_core import mips_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst_n,
    // Instruction port, read in the same cycle
    output word_t     imem_addr,
    input  word_t     imem_data,
    // Wishbone classic data master
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output word_t     wb_adr,
    output word_t     wb_dat_w,
    input  word_t     wb_dat_r,
    input  logic      wb_ack,
    // Retirement port
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata
);

    word_t   if_pc_plus_4;
    word_t   if_instr;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    load_use_stall;
    logic    mem_stall;
    logic    branch_taken;
    word_t   branch_target;
    word_t   wb_result;

    // ========================================================
    // Writeback
    // ========================================================
    assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;
    assign rf_we     = mem_wb.valid && mem_wb.reg_write && !mem_stall  // Once per instruction
                     && (mem_wb.dest != '0);
    assign rf_waddr  = mem_wb.dest;
    assign rf_wdata  = wb_result;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk (clk), .rst_n (rst_n),
        .imem_data (imem_data), .load_use_stall (load_use_stall),
        .mem_stall (mem_stall), .branch_taken (branch_taken),
        .branch_target (branch_target), .imem_addr (imem_addr),
        .if_pc_plus_4 (if_pc_plus_4), .if_instr (if_instr)
    );

    decode_stage u_decode (
        .clk (clk), .rst_n (rst_n),
        .if_pc_plus_4 (if_pc_plus_4), .if_instr (if_instr),
        .mem_stall (mem_stall), .branch_taken (branch_taken),
        .wb_we (rf_we), .wb_addr (rf_waddr), .wb_data (wb_result),
        .id_ex (id_ex), .load_use_stall (load_use_stall)
    );

    execute_stage u_execute (
        .clk (clk), .rst_n (rst_n),
        .id_ex (id_ex), .mem_stall (mem_stall),
        .wb_we (rf_we), .wb_addr (rf_waddr), .wb_data (wb_result),
        .ex_mem (ex_mem), .branch_taken (branch_taken), .branch_target (branch_target)
    );

    memory_stage u_memory (
        .clk (clk), .rst_n (rst_n),
        .ex_mem (ex_mem), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w),
        .mem_wb (mem_wb), .mem_stall (mem_stall)
    );

endmodule

//--- src/memory_stage.sv
// ============================================================
// Memory access: Wishbone classic master, pipeline freeze
// and the MEM/WB register
// ============================================================

module memory_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    input  word_t   wb_dat_r,
    input  logic    wb_ack,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output word_t   wb_adr,
    output word_t   wb_dat_w,
    output mem_wb_t mem_wb,
    output logic    mem_stall
);

    logic  req;     // Load or store sitting in MEM
    logic  done;    // Ack seen, release next cycle
    word_t load_q;  // Read data captured on ack

    assign req = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // Request held stable by the frozen EX/MEM register
    assign wb_cyc    = req && !done;
    assign wb_stb    = wb_cyc;
    assign wb_we     = ex_mem.mem_write;
    assign wb_adr    = ex_mem.alu_result;
    assign wb_dat_w  = ex_mem.store_data;
    assign mem_stall = req && !done;  // High up to and including the ack cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            done <= 1'b0;
        else if (wb_cyc && wb_ack)
            done <= 1'b1;
        else if (!mem_stall)
            done <= 1'b0;  // Pipeline advanced
    end

    always_ff @(posedge clk) begin
        if (wb_cyc && wb_ack)
            load_q <= wb_dat_r;
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (!mem_stall) begin
            mem_wb <= '{valid: ex_mem.valid, mem_to_reg: ex_mem.mem_to_reg,
                        reg_write: ex_mem.reg_write, alu_result: ex_mem.alu_result,
                        load_data: load_q, dest: ex_mem.dest};
        end
    end

endmodule

//--- src/execute_stage.sv
// ============================================================
// Execute: operand forwarding, ALU control and ALU,
// branch resolution and the EX/MEM register
// ============================================================

module execute_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  id_ex_t    id_ex,
    input  logic      mem_stall,
    input  logic      wb_we,          // Write retiring in WB
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output ex_mem_t   ex_mem,
    output logic      branch_taken,
    output word_t     branch_target
);

    word_t     op_a;
    word_t     rt_fwd;    // Forwarded rt, also the store data
    word_t     op_b;
    alu_op_t   alu_op;
    word_t     alu_y;
    logic      zero;
    reg_addr_t dest;
    logic      is_branch;

    // ========================================================
    // Forwarding
    // ========================================================
    // MEM beats WB; loads in MEM are covered by the load-use bubble
    function automatic word_t fwd(input reg_addr_t src, input word_t rf_val);
        if (src == '0)
            return rf_val;
        else if (ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_to_reg && ex_mem.dest == src)
            return ex_mem.alu_result;
        else if (wb_we && wb_addr == src)
            return wb_data;
        else
            return rf_val;
    endfunction

    always_comb begin
        op_a   = fwd(id_ex.rs, id_ex.rs_data);
        rt_fwd = fwd(id_ex.rt, id_ex.rt_data);
        op_b   = id_ex.ctrl.alu_src ? id_ex.imm : rt_fwd;
    end

    // ========================================================
    // ALU control and ALU
    // ========================================================
    assign is_branch = id_ex.ctrl.branch_eq || id_ex.ctrl.branch_ne;

    always_comb begin
        alu_op = ALU_ADD;                // Address and addi default
        if (is_branch) begin
            alu_op = ALU_SUB;            // Zero flag gives equality
        end else if (id_ex.ctrl.alu_sel) begin
            case (id_ex.funct)
                FUNCT_SUB: alu_op = ALU_SUB;
                FUNCT_AND: alu_op = ALU_AND;
                FUNCT_OR:  alu_op = ALU_OR;
                FUNCT_SLT: alu_op = ALU_SLT;
                default:   alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_y = op_a + op_b;
        endcase
    end

    assign zero = (alu_y == '0);
    assign dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

    // Branch resolves here, fetch redirects on the next edge
    assign branch_taken  = id_ex.valid && ((id_ex.ctrl.branch_eq && zero)
                                       || (id_ex.ctrl.branch_ne && !zero));
    assign branch_target = id_ex.pc_plus_4 + {id_ex.imm[29:0], 2'b00};

    // ========================================================
    // EX/MEM register
    // ========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!mem_stall) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= rt_fwd;
            ex_mem.dest       <= dest;
        end
    end

endmodule

//--- src/decode_stage.sv
// ============================================================
// Instruction decode: field split, control decode,
// sign extension, load-use detection, ID/EX register
// ============================================================

module decode_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     if_pc_plus_4,
    input  word_t     if_instr,
    input  logic      mem_stall,
    input  logic      branch_taken,
    input  logic      wb_we,       // Register write from WB
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output id_ex_t    id_ex,
    output logic      load_use_stall
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm;
    word_t      rs_data;
    word_t      rt_data;
    ctrl_t      ctrl;
    logic       legal;    // Known instruction
    logic       uses_rt;  // rt is a source operand

    // Field split
    assign opcode = if_instr[31:26];
    assign rs     = if_instr[25:21];
    assign rt     = if_instr[20:16];
    assign rd     = if_instr[15:11];
    assign funct  = if_instr[5:0];
    assign imm    = {{16{if_instr[15]}}, if_instr[15:0]};

    register_file u_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (rs),
        .rt      (rt),
        .we      (wb_we),
        .waddr   (wb_addr),
        .wdata   (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // ========================================================
    // Control decode
    // ========================================================
    always_comb begin
        ctrl  = '0;
        legal = 1'b1;
        case (opcode)
            OPC_RTYPE: begin
                if (funct inside {FUNCT_ADD, FUNCT_SUB, FUNCT_AND, FUNCT_OR, FUNCT_SLT}) begin
                    ctrl.reg_dst   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_sel   = 1'b1;
                end else begin
                    legal = 1'b0;  // Also the all-zero no-op
                end
            end
            OPC_ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
            end
            OPC_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OPC_BEQ: ctrl.branch_eq = 1'b1;  // Compare by subtract in EX
            OPC_BNE: ctrl.branch_ne = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    // R-type, branches and stores read rt, addi and lw only write it
    assign uses_rt = !ctrl.alu_src || ctrl.mem_write;

    // Load in EX whose rt feeds the instruction in ID
    assign load_use_stall = legal && id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rt != '0)
                          && ((id_ex.rt == rs) || (uses_rt && id_ex.rt == rt));

    // ========================================================
    // ID/EX register
    // ========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!mem_stall) begin
            if (load_use_stall || branch_taken) begin
                id_ex <= '0;  // Bubble
            end else begin
                id_ex <= '{valid: legal, ctrl: ctrl, pc_plus_4: if_pc_plus_4,
                           rs_data: rs_data, rt_data: rt_data, imm: imm,
                           rs: rs, rt: rt, rd: rd, funct: funct};
            end
        end
    end

endmodule

//--- src/fetch_stage.sv
// ============================================================
// Instruction fetch: program counter, next-PC select
// and the IF/ID register
// ============================================================

module fetch_stage import mips_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t imem_data,       // Combinational ROM read
    input  logic  load_use_stall,
    input  logic  mem_stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t imem_addr,
    output word_t if_pc_plus_4,
    output word_t if_instr
);

    word_t pc;
    word_t pc_plus_4;

    assign imem_addr = pc;
    assign pc_plus_4 = pc + 32'd4;

    // Bus freeze wins, then redirect, then load-use hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= RESET_PC;
            if_pc_plus_4 <= '0;
            if_instr     <= '0;             // All-zero word decodes as no-op
        end else if (mem_stall) begin
            // Everything holds
        end else if (branch_taken) begin
            pc           <= branch_target;  // Redirect on this edge
            if_pc_plus_4 <= '0;
            if_instr     <= '0;             // Squash the fetched instruction
        end else if (!load_use_stall) begin
            pc           <= pc_plus_4;
            if_pc_plus_4 <= pc_plus_4;
            if_instr     <= imem_data;
        end
    end

endmodule

//--- src/register_file.sv
// ============================================================
// 32 x 32 register file, two read ports, one write port
// Writes bypass to the read ports in the same cycle
// ============================================================

module register_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [32];
    logic  wr_live;  // A real write this cycle

    assign wr_live = we && (waddr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;  // Register 0 never written
        end
    end

    // Write-before-read so ID sees the value WB is retiring
    assign rs_data = (wr_live && waddr == rs) ? wdata : regs[rs];
    assign rt_data = (wr_live && waddr == rt) ? wdata : regs[rt];

endmodule

//--- src/mips_pkg.sv
// ============================================================
// Shared definitions for the five-stage MIPS core
// Data widths, opcode and funct constants, ALU codes
// Decoded control and pipeline-register structs
// ============================================================

package mips_pkg;

    typedef logic [31:0] word_t;      // Data word or byte address
    typedef logic [4:0]  reg_addr_t;  // Register index
    typedef logic [2:0]  alu_op_t;    // ALU operation code

    // ========================================================
    // Instruction encodings
    // ========================================================
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;

    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_SLT = 6'h2a;

    // ALU operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // ========================================================
    // Control and pipeline registers
    // ========================================================
    typedef struct packed {
        logic reg_dst;     // Destination is rd, else rt
        logic alu_src;     // Operand B is the immediate
        logic mem_to_reg;  // Writeback takes load data
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch_eq;
        logic branch_ne;
        logic alu_sel;     // 1: op from funct field, 0: plain add
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pc_plus_4;
        word_t      rs_data;
        word_t      rt_data;
        word_t      imm;        // Sign-extended immediate
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [5:0] funct;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      mem_to_reg;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        word_t     alu_result;  // Also the bus address
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      mem_to_reg;
        logic      reg_write;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage
